/* Makefile */
VERILATOR := verilator
VFLAGS    := --binary --timing --assert
TOP       := tb_sw_top
FLIST     := flist.f
PASS_MSG  := TESTBENCH PASSED

BUILD_DIR := obj_dir
BIN       := $(BUILD_DIR)/V$(TOP)
SRCS      := $(filter %.sv %.v,$(shell cat $(FLIST)))
HDRS      := $(wildcard design/*.svh sim/*.svh)

.PHONY: all run clean

all: run

$(BIN): $(SRCS) $(HDRS) $(FLIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(BUILD_DIR)

run: $(BIN)
	@out="$$($(BIN))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)

/* design/sw_array_ctrl.sv */
`timescale 1ns/1ps
`include "sw_config.svh"

module sw_array_ctrl (
	input  logic                                clk,
	input  logic                                rst_n,
	input  logic                                i_start,
	input  logic                                i_loaded,
	input  sw_pkg::sym_t [`SW_ARRAY_SIZE-1:0]   i_q_syms,
	input  sw_pkg::qlen_t                       i_qlen,
	input  sw_pkg::sym_t                        i_t_sym,
	input  logic                                i_t_valid,
	input  logic                                i_t_last,
	input  sw_pkg::score_t                      i_match,
	input  sw_pkg::score_t                      i_mismatch,
	input  sw_pkg::score_t                      i_gap_open,
	input  sw_pkg::score_t                      i_gap_extend,
	output logic                                o_clear,
	output sw_pkg::score_t                      o_score,
	output logic                                o_done,
	output logic                                o_busy
);

	sw_pkg::ctrl_state_t state, state_n;
	logic [`SW_ARRAY_SIZE-1:0] mask, mask_n;
	logic [`SW_ARRAY_LOG:0]    drain_cnt, drain_cnt_n;
	sw_pkg::score_t            score_q, score_n;
	logic                      clear;

	// Systolic chain with index 0 as the array input
	sw_pkg::sym_t   chain_t [`SW_ARRAY_SIZE+1];
	logic           chain_v [`SW_ARRAY_SIZE+1];
	sw_pkg::score_t chain_h [`SW_ARRAY_SIZE+1];
	sw_pkg::score_t chain_f [`SW_ARRAY_SIZE+1];
	sw_pkg::score_t [`SW_ARRAY_SIZE-1:0] h_all;
	sw_pkg::score_t tree_max;

	assign clear = (state == sw_pkg::IDLE) && i_start;

	always_comb begin
		state_n     = state;
		mask_n      = mask;
		drain_cnt_n = drain_cnt;
		score_n     = score_q;

		case (state)
			sw_pkg::IDLE: begin
				if (i_start) begin
					state_n = sw_pkg::LOAD;
					mask_n  = '0;
				end
			end

			sw_pkg::LOAD: begin
				// Only cells below qlen take part
				if (i_loaded) begin
					state_n = sw_pkg::CALC;
					for (int k = 0; k < `SW_ARRAY_SIZE; k++)
						mask_n[k] = (k < int'(i_qlen));
				end
			end

			sw_pkg::CALC: begin
				if (i_t_valid && i_t_last) begin
					state_n     = sw_pkg::DRAIN;
					drain_cnt_n = i_qlen + 4'd3;
				end
			end

			sw_pkg::DRAIN: begin
				// Last wave crosses the chain and the tree
				if (drain_cnt == '0) begin
					state_n = sw_pkg::DONE;
					score_n = tree_max;
				end else begin
					drain_cnt_n = drain_cnt - 1'b1;
				end
			end

			sw_pkg::DONE: begin
				state_n = sw_pkg::IDLE;
			end

			default: begin
				state_n = sw_pkg::IDLE;
			end
		endcase
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state     <= sw_pkg::IDLE;
			mask      <= '0;
			drain_cnt <= '0;
			score_q   <= '0;
		end else begin
			state     <= state_n;
			mask      <= mask_n;
			drain_cnt <= drain_cnt_n;
			score_q   <= score_n;
		end
	end

	assign o_clear = clear;
	assign o_score = score_q;
	assign o_done  = (state == sw_pkg::DONE);
	assign o_busy  = (state != sw_pkg::IDLE);

	// Target enters cell 0 only while calculating
	assign chain_t[0] = i_t_sym;
	assign chain_v[0] = i_t_valid && (state == sw_pkg::CALC);
	assign chain_h[0] = '0;
	assign chain_f[0] = '0;

	for (genvar k = 0; k < `SW_ARRAY_SIZE; k++) begin : g_pe
		sw_pe u_pe (
			.clk          (clk),
			.rst_n        (rst_n),
			.i_clear      (clear),
			.i_enable     (mask[k]),
			.i_q_sym      (i_q_syms[k]),
			.i_t_sym      (chain_t[k]),
			.i_t_valid    (chain_v[k]),
			.i_h_left     (chain_h[k]),
			.i_f_left     (chain_f[k]),
			.i_match      (i_match),
			.i_mismatch   (i_mismatch),
			.i_gap_open   (i_gap_open),
			.i_gap_extend (i_gap_extend),
			.o_t_sym      (chain_t[k+1]),
			.o_t_valid    (chain_v[k+1]),
			.o_h          (chain_h[k+1]),
			.o_f          (chain_f[k+1])
		);

		assign h_all[k] = chain_h[k+1];
	end

	sw_max_tree u_max_tree (
		.clk     (clk),
		.rst_n   (rst_n),
		.i_clear (clear),
		.i_h_all (h_all),
		.o_max   (tree_max)
	);

endmodule

/* design/sw_config.svh */
`ifndef SW_CONFIG_SVH
`define SW_CONFIG_SVH

// Cells in the chain, also the longest query
`define SW_ARRAY_SIZE 8
`define SW_ARRAY_LOG  3

// Nucleotide code and score widths
`define SW_SYM_BITS   2
`define SW_SCORE_BITS 12

`endif

/* design/sw_max_tree.sv */
`timescale 1ns/1ps
`include "sw_config.svh"

module sw_max_tree (
	input  logic                                  clk,
	input  logic                                  rst_n,
	input  logic                                  i_clear,
	input  sw_pkg::score_t [`SW_ARRAY_SIZE-1:0]   i_h_all,
	output sw_pkg::score_t                        o_max
);

	sw_pkg::score_t lvl1 [`SW_ARRAY_SIZE/2];
	sw_pkg::score_t lvl2 [`SW_ARRAY_SIZE/4];
	sw_pkg::score_t lvl3;
	sw_pkg::score_t run_max;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			for (int k = 0; k < `SW_ARRAY_SIZE/2; k++)
				lvl1[k] <= '0;
			for (int k = 0; k < `SW_ARRAY_SIZE/4; k++)
				lvl2[k] <= '0;
			lvl3    <= '0;
			run_max <= '0;
		end else if (i_clear) begin
			for (int k = 0; k < `SW_ARRAY_SIZE/2; k++)
				lvl1[k] <= '0;
			for (int k = 0; k < `SW_ARRAY_SIZE/4; k++)
				lvl2[k] <= '0;
			lvl3    <= '0;
			run_max <= '0;
		end else begin
			// Pairwise reduction, one level per cycle
			for (int k = 0; k < `SW_ARRAY_SIZE/2; k++)
				lvl1[k] <= (i_h_all[2*k] > i_h_all[2*k+1]) ? i_h_all[2*k] : i_h_all[2*k+1];
			for (int k = 0; k < `SW_ARRAY_SIZE/4; k++)
				lvl2[k] <= (lvl1[2*k] > lvl1[2*k+1]) ? lvl1[2*k] : lvl1[2*k+1];
			lvl3 <= (lvl2[0] > lvl2[1]) ? lvl2[0] : lvl2[1];

			// Best score since the job started
			if (lvl3 > run_max)
				run_max <= lvl3;
		end
	end

	assign o_max = run_max;

endmodule

/* design/sw_pe.sv */
`timescale 1ns/1ps
`include "sw_config.svh"

module sw_pe (
	input  logic           clk,
	input  logic           rst_n,
	input  logic           i_clear,
	input  logic           i_enable,
	input  sw_pkg::sym_t   i_q_sym,
	input  sw_pkg::sym_t   i_t_sym,
	input  logic           i_t_valid,
	input  sw_pkg::score_t i_h_left,
	input  sw_pkg::score_t i_f_left,
	input  sw_pkg::score_t i_match,
	input  sw_pkg::score_t i_mismatch,
	input  sw_pkg::score_t i_gap_open,
	input  sw_pkg::score_t i_gap_extend,
	output sw_pkg::sym_t   o_t_sym,
	output logic           o_t_valid,
	output sw_pkg::score_t o_h,
	output sw_pkg::score_t o_f
);

	sw_pkg::score_t e_q;
	sw_pkg::score_t h_diag;
	sw_pkg::score_t diag_c;
	sw_pkg::score_t e_open, e_ext, e_c;
	sw_pkg::score_t f_open, f_ext, f_c;
	sw_pkg::score_t h_c;
	logic           step;

	assign step = i_t_valid & i_enable;

	// Diagonal move with a zero floor on mismatch
	always_comb begin
		if (i_q_sym == i_t_sym)
			diag_c = h_diag + i_match;
		else
			diag_c = (h_diag > i_mismatch) ? h_diag - i_mismatch : '0;
	end

	// Gap along the target uses this cell's last H and E
	assign e_open = (o_h > i_gap_open) ? o_h - i_gap_open : '0;
	assign e_ext  = (e_q > i_gap_extend) ? e_q - i_gap_extend : '0;
	assign e_c    = (e_open > e_ext) ? e_open : e_ext;

	// Gap along the query comes in from the left cell
	assign f_open = (i_h_left > i_gap_open) ? i_h_left - i_gap_open : '0;
	assign f_ext  = (i_f_left > i_gap_extend) ? i_f_left - i_gap_extend : '0;
	assign f_c    = (f_open > f_ext) ? f_open : f_ext;

	// Zero floor comes from the unsigned terms
	always_comb begin
		h_c = diag_c;
		if (e_c > h_c)
			h_c = e_c;
		if (f_c > h_c)
			h_c = f_c;
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			o_t_valid <= 1'b0;
			o_h       <= '0;
			o_f       <= '0;
			e_q       <= '0;
			h_diag    <= '0;
		end else if (i_clear) begin
			o_t_valid <= 1'b0;
			o_h       <= '0;
			o_f       <= '0;
			e_q       <= '0;
			h_diag    <= '0;
		end else begin
			o_t_valid <= i_t_valid;
			if (step) begin
				o_h    <= h_c;
				o_f    <= f_c;
				e_q    <= e_c;
				h_diag <= i_h_left;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (i_t_valid)
			o_t_sym <= i_t_sym;
	end

endmodule

/* design/sw_pkg.sv */
`include "sw_config.svh"

package sw_pkg;

	// One nucleotide code
	typedef logic [`SW_SYM_BITS-1:0] sym_t;

	// Unsigned alignment score
	typedef logic [`SW_SCORE_BITS-1:0] score_t;

	// Query length, 1 up to the array size
	typedef logic [`SW_ARRAY_LOG:0] qlen_t;

	typedef enum logic [2:0] {
		IDLE,
		LOAD,
		CALC,
		DRAIN,
		DONE
	} ctrl_state_t;

endpackage

/* design/sw_query_loader.sv */
`timescale 1ns/1ps
`include "sw_config.svh"

module sw_query_loader (
	input  logic                                clk,
	input  logic                                rst_n,
	input  logic                                i_clear,
	input  sw_pkg::sym_t                        i_q_sym,
	input  logic                                i_q_valid,
	input  logic                                i_q_last,
	output sw_pkg::sym_t [`SW_ARRAY_SIZE-1:0]   o_q_syms,
	output sw_pkg::qlen_t                       o_qlen,
	output logic                                o_loaded
);

	sw_pkg::sym_t [`SW_ARRAY_SIZE-1:0] q_syms;
	sw_pkg::qlen_t                     count;
	logic                              loaded;
	logic                              take;

	// Symbols arriving once the query is complete are dropped
	assign take = i_q_valid & ~loaded & ~i_clear;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			count  <= '0;
			loaded <= 1'b0;
		end else if (i_clear) begin
			count  <= '0;
			loaded <= 1'b0;
		end else if (take) begin
			count <= count + 1'b1;
			// Full array also ends the query
			if (i_q_last || count == sw_pkg::qlen_t'(`SW_ARRAY_SIZE - 1))
				loaded <= 1'b1;
		end
	end

	always_ff @(posedge clk) begin
		if (take)
			q_syms[count[`SW_ARRAY_LOG-1:0]] <= i_q_sym;
	end

	assign o_q_syms = q_syms;
	assign o_qlen   = count;
	assign o_loaded = loaded;

endmodule

/* design/sw_top.sv */
`timescale 1ns/1ps
`include "sw_config.svh"

module sw_top (
	input  logic           clk,
	input  logic           rst_n,
	input  logic           i_start,
	input  sw_pkg::sym_t   i_q_sym,
	input  logic           i_q_valid,
	input  logic           i_q_last,
	input  sw_pkg::sym_t   i_t_sym,
	input  logic           i_t_valid,
	input  logic           i_t_last,
	input  sw_pkg::score_t i_match,
	input  sw_pkg::score_t i_mismatch,
	input  sw_pkg::score_t i_gap_open,
	input  sw_pkg::score_t i_gap_extend,
	output logic           o_busy,
	output logic           o_done,
	output sw_pkg::score_t o_score
);

	sw_pkg::sym_t [`SW_ARRAY_SIZE-1:0] q_syms;
	sw_pkg::qlen_t                     qlen;
	logic                              loaded;
	logic                              clear;

	// Query capture
	sw_query_loader u_loader (
		.clk      (clk),
		.rst_n    (rst_n),
		.i_clear  (clear),
		.i_q_sym  (i_q_sym),
		.i_q_valid(i_q_valid),
		.i_q_last (i_q_last),
		.o_q_syms (q_syms),
		.o_qlen   (qlen),
		.o_loaded (loaded)
	);

	// Job sequencing, cell chain and score reduction
	sw_array_ctrl u_ctrl (
		.clk          (clk),
		.rst_n        (rst_n),
		.i_start      (i_start),
		.i_loaded     (loaded),
		.i_q_syms     (q_syms),
		.i_qlen       (qlen),
		.i_t_sym      (i_t_sym),
		.i_t_valid    (i_t_valid),
		.i_t_last     (i_t_last),
		.i_match      (i_match),
		.i_mismatch   (i_mismatch),
		.i_gap_open   (i_gap_open),
		.i_gap_extend (i_gap_extend),
		.o_clear      (clear),
		.o_score      (o_score),
		.o_done       (o_done),
		.o_busy       (o_busy)
	);

endmodule

/* flist.f */
+incdir+design
+incdir+sim
design/sw_pkg.sv
design/sw_pe.sv
design/sw_max_tree.sv
design/sw_query_loader.sv
design/sw_array_ctrl.sv
design/sw_top.sv
sim/tb_sw_top.sv

/* sim/tb_sw_model.svh */
`ifndef TB_SW_MODEL_SVH
`define TB_SW_MODEL_SVH

// Longest target the generators produce
localparam int MAX_TLEN = 40;

typedef sw_pkg::sym_t sym_q_t [$];

int unsigned lcg_state = 32'h031dbc9c;

function automatic int unsigned lcg_next();
	lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
	return lcg_state;
endfunction

// Upper LCG bits have the longer period
function automatic int rand_range(input int lo, input int hi);
	int unsigned span;
	span = hi - lo + 1;
	return lo + int'((lcg_next() >> 8) % span);
endfunction

function automatic sym_q_t random_seq(input int len);
	sym_q_t seq;
	for (int k = 0; k < len; k++)
		seq.push_back(sw_pkg::sym_t'(rand_range(0, 3)));
	return seq;
endfunction

function automatic int max2(input int a, input int b);
	return (a > b) ? a : b;
endfunction

// Full-matrix Gotoh local alignment with row i for query symbol i-1
function automatic int ref_score(input sym_q_t q, input sym_q_t t, input int m, input int mm,
		input int go, input int ge);
	int h [`SW_ARRAY_SIZE+1][MAX_TLEN+1];
	int e [`SW_ARRAY_SIZE+1][MAX_TLEN+1];
	int f [`SW_ARRAY_SIZE+1][MAX_TLEN+1];
	int diag;
	int best;
	best = 0;
	for (int i = 0; i <= `SW_ARRAY_SIZE; i++) begin
		for (int j = 0; j <= MAX_TLEN; j++) begin
			h[i][j] = 0;
			e[i][j] = 0;
			f[i][j] = 0;
		end
	end
	for (int j = 1; j <= t.size(); j++) begin
		for (int i = 1; i <= q.size(); i++) begin
			if (q[i-1] == t[j-1])
				diag = h[i-1][j-1] + m;
			else
				diag = max2(h[i-1][j-1] - mm, 0);
			e[i][j] = max2(max2(h[i][j-1] - go, e[i][j-1] - ge), 0);
			f[i][j] = max2(max2(h[i-1][j] - go, f[i-1][j] - ge), 0);
			h[i][j] = max2(max2(diag, e[i][j]), f[i][j]);
			best = max2(best, h[i][j]);
		end
	end
	return best;
endfunction

`endif

/* sim/tb_sw_top.sv */
`timescale 1ns/1ps
`include "sw_config.svh"

module tb_sw_top;

	`include "tb_sw_model.svh"

	localparam int NUM_DIRECTED = 7;
	localparam int NUM_RANDOM   = 40;
	localparam int TIMEOUT      = (NUM_DIRECTED + NUM_RANDOM) * (8 + MAX_TLEN * 2 + 20);
	// Query of the gap jobs with two bits per symbol and symbol 0 lowest
	localparam logic [15:0] GAP_QUERY = 16'hB1E4;

	logic           clk;
	logic           rst_n;
	logic           i_start;
	sw_pkg::sym_t   i_q_sym;
	logic           i_q_valid;
	logic           i_q_last;
	sw_pkg::sym_t   i_t_sym;
	logic           i_t_valid;
	logic           i_t_last;
	sw_pkg::score_t i_match;
	sw_pkg::score_t i_mismatch;
	sw_pkg::score_t i_gap_open;
	sw_pkg::score_t i_gap_extend;
	logic           o_busy;
	logic           o_done;
	sw_pkg::score_t o_score;

	sw_pkg::score_t exp_score;
	int             exp_qlen;
	logic           tb_idle;
	int             since_last  = 0;
	int             cycle_cnt   = 0;
	int             score_errs  = 0;
	int             timing_errs = 0;
	int             proto_errs  = 0;

	sw_top DUT (.*);

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	// The edge that takes the last target symbol counts as cycle one
	always @(posedge clk) begin
		cycle_cnt <= cycle_cnt + 1;
		if (i_t_valid && i_t_last)
			since_last <= 1;
		else
			since_last <= since_last + 1;
		if (cycle_cnt >= TIMEOUT) begin
			$display("Run stopped: no end after %0d cycles", TIMEOUT);
			finish_run(1'b1);
		end
	end

	// Sampled on the falling edge where DUT outputs are stable
	a_score: assert property (@(negedge clk) disable iff (!rst_n)
		$rose(o_done) |-> o_score == exp_score)
	else begin
		score_errs++;
		$display("[ERROR] o_score = 0x%h, expected 0x%h", o_score, exp_score);
	end

	a_done_time: assert property (@(negedge clk) disable iff (!rst_n)
		$rose(o_done) |-> since_last == exp_qlen + 5)
	else begin
		timing_errs++;
		$display("o_done came %0d cycles after the last target symbol instead of %0d",
			since_last, exp_qlen + 5);
	end

	a_done_pulse: assert property (@(negedge clk) disable iff (!rst_n) o_done |=> !o_done)
	else begin
		proto_errs++;
		$display("o_done stayed high for more than one cycle");
	end

	a_idle_busy: assert property (@(negedge clk) disable iff (!rst_n)
		(tb_idle || $past(o_done)) |-> !o_busy)
	else begin
		proto_errs++;
		$display("o_busy was high while no job was running");
	end

	task automatic finish_run(input logic timed_out);
		$display("Error counts: score %0d, timing %0d, protocol %0d",
			score_errs, timing_errs, proto_errs);
		if (!timed_out && score_errs + timing_errs + proto_errs == 0)
			$display("TESTBENCH PASSED");
		else
			$display("TESTBENCH FAILED");
		$finish;
	endtask

	// Starts on a falling edge and returns on the falling edge after DONE
	task automatic run_job(input sym_q_t q, input sym_q_t t, input int m, input int mm,
			input int go, input int ge, input int exp, input logic gaps,
			input logic full_last);
		exp_score    = sw_pkg::score_t'(exp);
		exp_qlen     = q.size();
		i_match      = sw_pkg::score_t'(m);
		i_mismatch   = sw_pkg::score_t'(mm);
		i_gap_open   = sw_pkg::score_t'(go);
		i_gap_extend = sw_pkg::score_t'(ge);
		tb_idle      = 1'b0;
		i_start      = 1'b1;
		@(negedge clk);
		i_start = 1'b0;
		for (int k = 0; k < q.size(); k++) begin
			if (gaps)
				repeat (rand_range(0, 2)) @(negedge clk);
			i_q_sym   = q[k];
			i_q_valid = 1'b1;
			i_q_last  = (k == q.size() - 1) && (full_last || q.size() < `SW_ARRAY_SIZE);
			@(negedge clk);
			i_q_valid = 1'b0;
			i_q_last  = 1'b0;
		end
		// The FSM reaches CALC one edge after loaded rises
		@(negedge clk);
		for (int k = 0; k < t.size(); k++) begin
			if (gaps)
				repeat (rand_range(0, 1)) @(negedge clk);
			i_t_sym   = t[k];
			i_t_valid = 1'b1;
			i_t_last  = (k == t.size() - 1);
			@(negedge clk);
			i_t_valid = 1'b0;
			i_t_last  = 1'b0;
		end
		while (o_done !== 1'b1)
			@(negedge clk);
		@(negedge clk);
		tb_idle = 1'b1;
	endtask

	initial begin
		sym_q_t q;
		sym_q_t t;
		int     m;
		int     mm;
		int     go;
		int     ge;
		int     off;
		rst_n        = 1'b0;
		i_start      = 1'b0;
		i_q_sym      = '0;
		i_q_valid    = 1'b0;
		i_q_last     = 1'b0;
		i_t_sym      = '0;
		i_t_valid    = 1'b0;
		i_t_last     = 1'b0;
		i_match      = '0;
		i_mismatch   = '0;
		i_gap_open   = '0;
		i_gap_extend = '0;
		exp_score    = '0;
		exp_qlen     = 0;
		tb_idle      = 1'b1;
		repeat (8) @(negedge clk);
		rst_n = 1'b1;
		@(negedge clk);

		// Identical pair where the eighth symbol ends the query by itself
		q = random_seq(`SW_ARRAY_SIZE);
		run_job(q, q, 7, 3, 5, 2, `SW_ARRAY_SIZE * 7, 1'b0, 1'b0);

		// Nothing in common right after a full score
		q.delete();
		t.delete();
		repeat (5) q.push_back(2'd0);
		for (int k = 0; k < 20; k++)
			t.push_back(sw_pkg::sym_t'(rand_range(1, 3)));
		run_job(q, t, 9, 2, 4, 1, 0, 1'b0, 1'b1);

		// Three extra target symbols mid-query with cheap then costly gaps
		q.delete();
		t.delete();
		for (int k = 0; k < `SW_ARRAY_SIZE; k++)
			q.push_back(GAP_QUERY[2*k +: 2]);
		for (int k = 0; k < `SW_ARRAY_SIZE; k++) begin
			if (k == 4)
				repeat (3) t.push_back(2'd2);
			t.push_back(q[k]);
		end
		run_job(q, t, 6, 4, 3, 1, ref_score(q, t, 6, 4, 3, 1), 1'b0, 1'b1);
		run_job(q, t, 6, 4, 15, 6, ref_score(q, t, 6, 4, 15, 6), 1'b0, 1'b1);

		// Same pair with and without idle cycles
		q = random_seq(5);
		t = random_seq(30);
		run_job(q, t, 5, 3, 6, 2, ref_score(q, t, 5, 3, 6, 2), 1'b0, 1'b1);
		run_job(q, t, 5, 3, 6, 2, ref_score(q, t, 5, 3, 6, 2), 1'b1, 1'b1);

		q = random_seq(1);
		run_job(q, q, 3, 1, 2, 1, 3, 1'b0, 1'b1);

		for (int n = 0; n < NUM_RANDOM; n++) begin
			q = random_seq(rand_range(1, `SW_ARRAY_SIZE));
			t = random_seq(rand_range(1, MAX_TLEN));
			// Plant the query in about half of the targets
			if (rand_range(0, 1) == 1 && t.size() >= q.size()) begin
				off = rand_range(0, t.size() - q.size());
				for (int k = 0; k < q.size(); k++)
					t[off + k] = q[k];
			end
			m  = rand_range(1, 15);
			mm = rand_range(0, 15);
			go = rand_range(0, 15);
			ge = rand_range(0, go);
			run_job(q, t, m, mm, go, ge, ref_score(q, t, m, mm, go, ge),
				rand_range(0, 1) == 1, rand_range(0, 1) == 1);
		end

		repeat (2) @(negedge clk);
		finish_run(1'b0);
	end

endmodule
